// ==== common/layer_norm_pkg.sv ====
package layer_norm_pkg;

    // vector geometry, LANES must stay a power of two
    localparam int LANES      = 8;
    localparam int LOG2_LANES = 3;

    // sample format Q3.4, shared by samples, gamma, beta and results
    localparam int DATA_WIDTH = 8;
    localparam int FRAC_WIDTH = 4;

    // statistics datapath widths
    localparam int SUM_WIDTH   = 11;
    localparam int DEV_WIDTH   = 9;
    // variance carries 2*FRAC_WIDTH fractional bits
    localparam int VAR_WIDTH   = 16;
    // std back at FRAC_WIDTH fractional bits
    localparam int STD_WIDTH   = 8;
    localparam int RECIP_FRAC  = 8;
    localparam int RECIP_WIDTH = 13;

    // internal widths derived from the above
    // squared-deviation accumulator before the divide by LANES
    localparam int ACC_WIDTH    = VAR_WIDTH + LOG2_LANES;
    // sqrt partial remainder
    localparam int SQ_REM_WIDTH = STD_WIDTH + 3;
    // step counter, must reach RECIP_WIDTH
    localparam int STEP_WIDTH   = 4;
    // deviation times zero-extended inv_std
    localparam int SCALE_WIDTH  = DEV_WIDTH + RECIP_WIDTH + 1;
    // scaled deviation times gamma
    localparam int PROD_WIDTH   = SCALE_WIDTH + DATA_WIDTH;
    localparam int NORM_SHIFT   = FRAC_WIDTH + RECIP_FRAC;

    // dividend of the reciprocal, 4096
    localparam logic [RECIP_WIDTH-1:0] RECIP_ONE = RECIP_WIDTH'(1) << NORM_SHIFT;

    // signed output limits
    localparam int SAMPLE_MAX = 2 ** (DATA_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (DATA_WIDTH - 1));

    // accept to stats_valid: mean, variance, sqrt, divide, result
    localparam int STATS_LATENCY = 1 + LANES + STD_WIDTH + RECIP_WIDTH + 1;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef sample_t [LANES-1:0] vec_t;

    // gamma of 1.0 in Q3.4
    localparam sample_t GAMMA_ONE = sample_t'(1 << FRAC_WIDTH);

    // per-lane affine parameters
    typedef struct packed {
        vec_t gamma;
        vec_t beta;
    } affine_t;

    // feeder to lanes, one vector plus its statistics
    typedef struct packed {
        sample_t                mean;
        logic [RECIP_WIDTH-1:0] inv_std;
        vec_t                   samples;
    } stats_t;

    typedef enum logic [2:0] {
        IDLE,
        VARIANCE,
        SQRT,
        DIVIDE,
        DONE
    } stats_state_e;

endpackage

// ==== stats/norm_stats.sv ====
`timescale 1ns/1ns

module norm_stats
(
    input  logic                   clk,
    input  logic                   reset,
    input  layer_norm_pkg::vec_t   in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic                   param_valid,
    output logic                   param_ready,
    output logic                   param_load,
    output layer_norm_pkg::stats_t stats,
    output logic                   stats_valid,
    input  logic                   stats_ready
);
    import layer_norm_pkg::*;

    stats_state_e                 state;
    logic [STEP_WIDTH-1:0]        step;
    logic                         accept;
    stats_t                       stats_r;

    // input sum and floored mean
    logic signed [SUM_WIDTH-1:0]  in_sum;
    sample_t                      in_mean;

    // variance accumulation
    logic signed [DEV_WIDTH-1:0]  dev;
    logic [2*DEV_WIDTH-1:0]       sq_r;
    logic [ACC_WIDTH-1:0]         acc;
    logic [VAR_WIDTH-1:0]         var_v;

    // restoring square root
    logic [SQ_REM_WIDTH-1:0]      sq_rem;
    logic [SQ_REM_WIDTH-1:0]      sq_rem_sh;
    logic [SQ_REM_WIDTH-1:0]      sq_trial;
    logic [STD_WIDTH-1:0]         root;
    logic [STD_WIDTH-1:0]         std_v;

    // restoring divide, quot starts as the dividend
    logic [STD_WIDTH-1:0]         div_rem;
    logic [STD_WIDTH:0]           div_rem_sh;
    logic [STD_WIDTH:0]           div_diff;
    logic [RECIP_WIDTH-1:0]       quot;

    // one vector at a time, params only between vectors
    assign in_ready    = (state == IDLE);
    assign param_ready = (state == IDLE);
    assign accept      = in_valid && in_ready;
    assign param_load  = param_valid && param_ready;
    assign stats_valid = (state == DONE);
    assign stats       = stats_r;

    always_comb
    begin
        in_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            in_sum = in_sum + SUM_WIDTH'(in_data[i]);
        end
        // arithmetic shift floors towards minus infinity
        in_mean = sample_t'(in_sum >>> LOG2_LANES);
    end

    always_comb
    begin
        logic [1:0] sq_pair;
        dev   = DEV_WIDTH'(stats_r.samples[step[LOG2_LANES-1:0]]) - DEV_WIDTH'(stats_r.mean);
        var_v = acc[ACC_WIDTH-1:LOG2_LANES];
        // two radicand bits per step, msb pair first
        sq_pair   = var_v[(VAR_WIDTH - 1) - 2 * step[2:0] -: 2];
        sq_rem_sh = {sq_rem[SQ_REM_WIDTH-3:0], sq_pair};
        sq_trial  = {1'b0, root, 2'b01};
        // zero std would blow up the reciprocal
        std_v      = (root == '0) ? STD_WIDTH'(1) : root;
        div_rem_sh = {div_rem, quot[RECIP_WIDTH-1]};
        div_diff   = div_rem_sh - {1'b0, std_v};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            step  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    step <= '0;
                    if (accept)
                        state <= VARIANCE;
                end
                VARIANCE:
                begin
                    // one extra step drains the squaring register
                    if (step == STEP_WIDTH'(LANES))
                    begin
                        state <= SQRT;
                        step  <= '0;
                    end
                    else
                        step <= step + 1'b1;
                end
                SQRT:
                begin
                    if (step == STEP_WIDTH'(STD_WIDTH - 1))
                    begin
                        state <= DIVIDE;
                        step  <= '0;
                    end
                    else
                        step <= step + 1'b1;
                end
                DIVIDE:
                begin
                    // last step only publishes the quotient
                    if (step == STEP_WIDTH'(RECIP_WIDTH))
                    begin
                        state <= DONE;
                        step  <= '0;
                    end
                    else
                        step <= step + 1'b1;
                end
                DONE:
                begin
                    if (stats_ready)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (accept)
                begin
                    stats_r.samples <= in_data;
                    stats_r.mean    <= in_mean;
                    acc             <= '0;
                    sq_r            <= '0;
                end
            end
            VARIANCE:
            begin
                acc <= acc + ACC_WIDTH'(sq_r);
                if (step < STEP_WIDTH'(LANES))
                    sq_r <= dev * dev;
                else
                    sq_r <= '0;
                sq_rem <= '0;
                root   <= '0;
            end
            SQRT:
            begin
                if (sq_rem_sh >= sq_trial)
                begin
                    sq_rem <= sq_rem_sh - sq_trial;
                    root   <= {root[STD_WIDTH-2:0], 1'b1};
                end
                else
                begin
                    sq_rem <= sq_rem_sh;
                    root   <= {root[STD_WIDTH-2:0], 1'b0};
                end
                // divider setup for the next phase
                div_rem <= '0;
                quot    <= RECIP_ONE;
            end
            DIVIDE:
            begin
                if (step < STEP_WIDTH'(RECIP_WIDTH))
                begin
                    if (!div_diff[STD_WIDTH])
                    begin
                        div_rem <= div_diff[STD_WIDTH-1:0];
                        quot    <= {quot[RECIP_WIDTH-2:0], 1'b1};
                    end
                    else
                    begin
                        div_rem <= div_rem_sh[STD_WIDTH-1:0];
                        quot    <= {quot[RECIP_WIDTH-2:0], 1'b0};
                    end
                end
                else
                    stats_r.inv_std <= quot;
            end
            default:
            begin
            end
        endcase
    end

endmodule

// ==== verilog/norm_lane.sv ====
`timescale 1ns/1ns

module norm_lane
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  param_load,
    input  layer_norm_pkg::sample_t               gamma,
    input  layer_norm_pkg::sample_t               beta,
    input  layer_norm_pkg::sample_t               mean,
    input  logic [layer_norm_pkg::RECIP_WIDTH-1:0] inv_std,
    input  layer_norm_pkg::sample_t               sample,
    output layer_norm_pkg::sample_t               result
);
    import layer_norm_pkg::*;

    sample_t                        gamma_r;
    sample_t                        beta_r;
    logic signed [DEV_WIDTH-1:0]    dev;
    logic signed [SCALE_WIDTH-1:0]  scaled;
    logic signed [PROD_WIDTH-1:0]   prod;
    logic signed [PROD_WIDTH-1:0]   biased;

    // identity transform until the first load
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gamma_r <= GAMMA_ONE;
            beta_r  <= '0;
        end
        else if (param_load)
        begin
            gamma_r <= gamma;
            beta_r  <= beta;
        end
    end

    always_comb
    begin
        dev    = DEV_WIDTH'(sample) - DEV_WIDTH'(mean);
        // inv_std is unsigned, keep it positive
        scaled = SCALE_WIDTH'(dev) * $signed({1'b0, inv_std});
        prod   = PROD_WIDTH'(scaled) * PROD_WIDTH'(gamma_r);
        // drop the gamma and reciprocal fractions, floor
        biased = (prod >>> NORM_SHIFT) + PROD_WIDTH'(beta_r);
        if (biased > SAMPLE_MAX)
            result = sample_t'(SAMPLE_MAX);
        else if (biased < SAMPLE_MIN)
            result = sample_t'(SAMPLE_MIN);
        else
            result = sample_t'(biased);
    end

endmodule

// ==== verilog/norm_collector.sv ====
`timescale 1ns/1ns

module norm_collector
(
    input  logic                 clk,
    input  logic                 reset,
    input  layer_norm_pkg::vec_t lane_results,
    input  logic                 stats_valid,
    output logic                 stats_ready,
    output layer_norm_pkg::vec_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic load;
    logic drain;

    // free slot, or the held vector leaves this cycle
    assign stats_ready = !out_valid || out_ready;
    assign load        = stats_valid && stats_ready;
    assign drain       = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (load)
        begin
            // covers load and drain in one cycle, no bubble
            out_valid <= 1'b1;
        end
        else if (drain)
        begin
            out_valid <= 1'b0;
        end
    end

    // lane outputs are only meaningful on the stats transfer
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_data <= lane_results;
        end
    end

endmodule

// ==== verilog/layer_norm_top.sv ====
`timescale 1ns/1ns

module layer_norm_top
(
    input  logic                    clk,
    input  logic                    reset,
    input  layer_norm_pkg::vec_t    in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  layer_norm_pkg::affine_t param_data,
    input  logic                    param_valid,
    output logic                    param_ready,
    output layer_norm_pkg::vec_t    out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import layer_norm_pkg::*;

    stats_t stats;
    logic   stats_valid;
    logic   stats_ready;
    logic   param_load;
    vec_t   lane_results;

    // serial statistics, one vector in flight
    norm_stats u_stats
    (
        .clk         (clk),
        .reset       (reset),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .param_valid (param_valid),
        .param_ready (param_ready),
        .param_load  (param_load),
        .stats       (stats),
        .stats_valid (stats_valid),
        .stats_ready (stats_ready)
    );

    // lane i owns sample i and its own gamma and beta
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        norm_lane u_lane
        (
            .clk        (clk),
            .reset      (reset),
            .param_load (param_load),
            .gamma      (param_data.gamma[i]),
            .beta       (param_data.beta[i]),
            .mean       (stats.mean),
            .inv_std    (stats.inv_std),
            .sample     (stats.samples[i]),
            .result     (lane_results[i])
        );
    end

    // output buffer, absorbs out_ready back-pressure
    norm_collector u_collector
    (
        .clk          (clk),
        .reset        (reset),
        .lane_results (lane_results),
        .stats_valid  (stats_valid),
        .stats_ready  (stats_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

// ==== dv/layer_norm_chk.sv ====
`timescale 1ns/1ns

module layer_norm_chk
(
    input logic                   clk,
    input logic                   reset,
    input logic                   in_valid,
    input logic                   in_ready,
    input layer_norm_pkg::vec_t   out_data,
    input logic                   out_valid,
    input logic                   out_ready,
    input layer_norm_pkg::stats_t stats,
    input logic                   stats_valid,
    input logic                   stats_ready,
    input logic                   param_load
);

    // vector sits in the feeder from input transfer to stats transfer
    logic in_flight;

    always_ff @(posedge clk)
    begin
        if (reset)
            in_flight <= 1'b0;
        else if (in_valid && in_ready)
            in_flight <= 1'b1;
        else if (stats_valid && stats_ready)
            in_flight <= 1'b0;
    end

    // both valids come out of reset low
    reset_state: assert property (@(posedge clk) reset |=> !out_valid && !stats_valid)
        else $error("valid high right after reset");

    // output held stable until taken
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output dropped or changed before out_ready");

    // stats held stable until the collector takes them
    stats_hold: assert property (@(posedge clk) disable iff (reset)
        stats_valid && !stats_ready |=> stats_valid && $stable(stats))
        else $error("stats dropped or changed before stats_ready");

    // gamma and beta never move under a vector in the feeder
    param_idle: assert property (@(posedge clk) disable iff (reset)
        param_load |-> !in_flight)
        else $error("parameter load while a vector is in the feeder");

endmodule

// ==== dv/layer_norm_tb.sv ====
`timescale 1ns/1ns

module layer_norm_tb;
    import layer_norm_pkg::*;

    localparam int SEED         = 25344;
    localparam int RESET_CYCLES = 8;
    // identity, affine, flat, clip, back-pressure
    localparam int NUM_VECTORS  = 50 + 50 + 4 + 4 + 40;
    localparam longint TIMEOUT_CYCLES = longint'(NUM_VECTORS) * 4 * (STATS_LATENCY + 2) + 500;

    logic    clk;
    logic    reset;
    vec_t    in_data;
    logic    in_valid;
    logic    in_ready;
    affine_t param_data;
    logic    param_valid;
    logic    param_ready;
    vec_t    out_data;
    logic    out_valid;
    logic    out_ready;

    // scoreboard, expected vectors with their test names
    vec_t    exp_q[$];
    string   name_q[$];
    affine_t affine_cur;
    int      sent_count;
    int      recv_count;
    logic    bp_on;

    layer_norm_top DUT
    (
        .clk         (clk),
        .reset       (reset),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .param_data  (param_data),
        .param_valid (param_valid),
        .param_ready (param_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    bind layer_norm_top layer_norm_chk u_chk
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .stats       (stats),
        .stats_valid (stats_valid),
        .stats_ready (stats_ready),
        .param_load  (param_load)
    );

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_vec(string name, vec_t expected, vec_t actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic compare_bit(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            fail_run();
        end
    endtask

    // expected output straight from the layer-norm arithmetic
    function automatic vec_t reference_norm(vec_t x, affine_t p);
        vec_t   y;
        longint dev [LANES];
        longint sum;
        longint mean;
        longint sq_sum;
        longint var_v;
        longint std_v;
        longint inv;
        longint val;
        sum = 0;
        for (int i = 0; i < LANES; i++)
            sum += longint'($signed(x[i]));
        // floor towards minus infinity
        mean   = sum >>> LOG2_LANES;
        sq_sum = 0;
        for (int i = 0; i < LANES; i++)
        begin
            dev[i] = longint'($signed(x[i])) - mean;
            sq_sum += dev[i] * dev[i];
        end
        var_v = sq_sum >>> LOG2_LANES;
        std_v = 0;
        while ((std_v + 1) * (std_v + 1) <= var_v)
            std_v++;
        if (std_v == 0)
            std_v = 1;
        inv = (longint'(1) << (FRAC_WIDTH + RECIP_FRAC)) / std_v;
        for (int i = 0; i < LANES; i++)
        begin
            val = dev[i] * inv * longint'($signed(p.gamma[i]));
            val = (val >>> (FRAC_WIDTH + RECIP_FRAC)) + longint'($signed(p.beta[i]));
            if (val > SAMPLE_MAX)
                val = SAMPLE_MAX;
            else if (val < SAMPLE_MIN)
                val = SAMPLE_MIN;
            y[i] = sample_t'(val);
        end
        return y;
    endfunction

    function automatic vec_t random_vec();
        vec_t v;
        for (int i = 0; i < LANES; i++)
            v[i] = sample_t'($urandom_range(0, 255));
        return v;
    endfunction

    function automatic affine_t random_affine();
        affine_t a;
        for (int i = 0; i < LANES; i++)
        begin
            a.gamma[i] = sample_t'($urandom_range(0, 255));
            a.beta[i]  = sample_t'($urandom_range(0, 255));
        end
        return a;
    endfunction

    // wide-spread patterns that push the outputs into the rails
    function automatic sample_t spread_sample(int kind, int lane);
        case (kind)
            0:       return (lane % 2 == 1) ? sample_t'(127) : sample_t'(-128);
            1:       return (lane < LANES / 2) ? sample_t'(127) : sample_t'(-128);
            2:       return (lane == 0) ? sample_t'(127) : sample_t'(-128);
            default: return sample_t'(-128 + 36 * lane);
        endcase
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send_vec(string name, vec_t v, vec_t expected);
        in_data  = v;
        in_valid = 1'b1;
        while (!in_ready)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        exp_q.push_back(expected);
        name_q.push_back(name);
        sent_count++;
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_params(affine_t a);
        param_data  = a;
        param_valid = 1'b1;
        while (!param_ready)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        // lanes switch on this edge
        affine_cur = a;
        #1;
        param_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    // output side, ready mostly low while back-pressure is on
    always @(posedge clk)
    begin
        #1;
        if (bp_on)
            out_ready = ($urandom_range(0, 47) == 0);
        else
            out_ready = 1'b1;
    end

    // mid-cycle sample, transfer happens on the next rising edge
    always @(negedge clk)
    begin
        if (!reset && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("output vector arrived with no expected vector pending");
                fail_run();
            end
            else
            begin
                compare_vec(name_q.pop_front(), exp_q.pop_front(), out_data);
                recv_count++;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_CYCLES * 8);
        $display("watchdog expired after %0d cycles, the DUT stopped handshaking",
                 TIMEOUT_CYCLES);
        fail_run();
    end

    initial
    begin
        affine_t a;
        vec_t    v;
        sample_t s;
        void'($urandom(SEED));
        clk         = 1'b0;
        reset       = 1'b1;
        in_data     = '0;
        in_valid    = 1'b0;
        param_data  = '0;
        param_valid = 1'b0;
        out_ready   = 1'b1;
        bp_on       = 1'b0;
        sent_count  = 0;
        recv_count  = 0;
        // lane reset values, gamma 1.0 and beta 0
        for (int i = 0; i < LANES; i++)
        begin
            affine_cur.gamma[i] = sample_t'(1 << FRAC_WIDTH);
            affine_cur.beta[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        compare_bit("reset_in_ready", 1'b1, in_ready);
        compare_bit("reset_param_ready", 1'b1, param_ready);
        compare_bit("reset_out_valid", 1'b0, out_valid);

        repeat (50)
        begin
            v = random_vec();
            send_vec("identity", v, reference_norm(v, affine_cur));
        end

        // load lands only once the feeder is idle again
        send_params(random_affine());
        repeat (50)
        begin
            v = random_vec();
            send_vec("affine", v, reference_norm(v, affine_cur));
        end

        // equal samples, zero deviation, output is beta
        repeat (4)
        begin
            s = sample_t'($urandom_range(0, 255));
            for (int i = 0; i < LANES; i++)
                v[i] = s;
            send_vec("flat", v, affine_cur.beta);
        end

        a = random_affine();
        for (int i = 0; i < LANES; i++)
            a.gamma[i] = sample_t'(SAMPLE_MAX);
        send_params(a);
        for (int k = 0; k < 4; k++)
        begin
            for (int i = 0; i < LANES; i++)
                v[i] = spread_sample(k, i);
            send_vec("clip", v, reference_norm(v, affine_cur));
        end

        wait_drain();
        bp_on = 1'b1;
        repeat (40)
        begin
            v = random_vec();
            send_vec("backpressure", v, reference_norm(v, affine_cur));
        end
        wait_drain();
        bp_on = 1'b0;
        repeat (4) @(posedge clk);

        if (recv_count == sent_count && exp_q.size() == 0 && !out_valid)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("sent %0d vectors but received %0d", sent_count, recv_count);
            fail_run();
        end
    end

endmodule

// ==== compile.f ====
common/layer_norm_pkg.sv
stats/norm_stats.sv
verilog/norm_lane.sv
verilog/norm_collector.sv
verilog/layer_norm_top.sv
dv/layer_norm_chk.sv
dv/layer_norm_tb.sv

// ==== Makefile ====
# Verilator build and run of the layer-norm testbench

VERILATOR ?= verilator
TOP       ?= layer_norm_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
